/* mixer.f */
+incdir+sim
source/mixer_pkg.sv
source/word_stream_if.sv
source/port_packer.sv
source/word_fifo.sv
source/port_arbiter.sv
source/burst_writer.sv
source/mixer.sv
sim/tb_mixer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mixer testbench with Verilator
# the result is taken from the simulation log

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mixer -f mixer.f \
	-o tb_mixer > build.log 2>&1 \
	&& ./obj_dir/tb_mixer > sim.log 2>&1 \
	|| echo "build or simulation ended with an error status"

cat sim.log 2>/dev/null

grep -q "^TEST PASSED$" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sim/mixer_model.svh */
`ifndef MIXER_MODEL_SVH
`define MIXER_MODEL_SVH

// one expected memory write whose port follows from its address region
typedef struct packed {
	mem_word_t data;
	mem_addr_t addr;
} expected_beat_t;

expected_beat_t exp_q0[$];
expected_beat_t exp_q1[$];

// green takes the top six bits above red and blue
function automatic pixel_t pack_565(input logic [7:0] r, input logic [7:0] g,
		input logic [7:0] b);
	int value;
	value = (int'(g) / 4) * 1024 + (int'(r) / 8) * 32 + int'(b) / 8;
	return pixel_t'(value);
endfunction

function automatic mem_addr_t word_address(input int port, input int line, input int idx);
	return mem_addr_t'(port * PORT_REGION_BYTES + line * LINE_STRIDE_BYTES + idx * WORD_BYTES);
endfunction

task automatic expect_beat(input int port, input mem_word_t data, input int line,
		input int idx);
	expected_beat_t e;
	e.data = data;
	e.addr = word_address(port, line, idx);
	if (port == 0)
		exp_q0.push_back(e);
	else
		exp_q1.push_back(e);
endtask

task automatic abort_run(input string what);
	$display("%s", what);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
	if (exp !== act) begin
		$display("error %s: expected %h, actual %h", name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	end
endtask

task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
	if (exp !== act) begin
		$display("error %s: expected %h, actual %h", name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		$display("error %s: expected %b, actual %b", name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	end
endtask

`endif

/* sim/tb_mixer.sv */
`default_nettype none

module tb_mixer
	import mixer_pkg::*;
();
	localparam int LINE_PIXELS = 48;
	localparam int FIFO_DEPTH  = 16;
	localparam int BURST_WORDS = 4;

	localparam int NUM_LINES = 40;
	localparam int MIN_LINE  = 16;
	localparam int MAX_LINE  = 64;
	localparam int MIN_BLANK = 6;
	localparam int MAX_BLANK = 25;
	// six words per line put the total well past the FIFO depth
	localparam int OVF_LINES = 4;

	localparam int STIM_CYCLES    = (NUM_LINES + 2) * (MAX_LINE + MAX_BLANK);
	localparam int DRAIN_CYCLES   = 1000;
	localparam int OVF_CYCLES     = OVF_LINES * (LINE_PIXELS + MIN_BLANK) + 50;
	localparam int TIMEOUT_CYCLES = 10 + STIM_CYCLES + DRAIN_CYCLES + OVF_CYCLES;

	logic       pclk0;
	logic       vrst;
	logic       hs [2];
	logic       vs [2];
	logic       de [2];
	logic [7:0] r [2];
	logic [7:0] g [2];
	logic [7:0] b [2];
	logic       mem_wr_full;
	logic       mem_wr_en;
	logic       mem_cmd_en;
	mem_word_t  mem_wr_data;
	mem_addr_t  mem_wr_addr;
	logic       overflow0;
	logic       overflow1;

	integer seed;

	// video generator state with one slot per port
	int        pix_left [2];
	int        line_len [2];
	int        blank_left [2];
	int        blank_pos [2];
	logic      frame_start [2];
	int        lines_done [2];
	int        line_no [2];
	int        words_made [2];
	logic      padded [2];
	logic      port_done [2];
	mem_word_t build [2];

	int       full_left;
	int       beat_total;
	port_id_t burst_port;
	logic     prev_full;

	`include "mixer_model.svh"

	mixer #(
		.LINE_PIXELS (LINE_PIXELS),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.BURST_WORDS (BURST_WORDS)
	) i_mixer (
		.pclk0       (pclk0),
		.vrst        (vrst),
		.hs0         (hs[0]),
		.vs0         (vs[0]),
		.de0         (de[0]),
		.r0          (r[0]),
		.g0          (g[0]),
		.b0          (b[0]),
		.hs1         (hs[1]),
		.vs1         (vs[1]),
		.de1         (de[1]),
		.r1          (r[1]),
		.g1          (g[1]),
		.b1          (b[1]),
		.mem_wr_full (mem_wr_full),
		.mem_wr_en   (mem_wr_en),
		.mem_cmd_en  (mem_cmd_en),
		.mem_wr_data (mem_wr_data),
		.mem_wr_addr (mem_wr_addr),
		.overflow0   (overflow0),
		.overflow1   (overflow1)
	);

	always #50 pclk0 = ~pclk0;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic start_blank(input int p);
		blank_left[p]  = MIN_BLANK + rand_below(MAX_BLANK - MIN_BLANK + 1);
		blank_pos[p]   = 0;
		frame_start[p] = (rand_below(6) == 0);
	endtask

	task automatic next_line(input int p);
		int need;
		need = (BURST_WORDS - words_made[p] % BURST_WORDS) % BURST_WORDS;
		if (lines_done[p] < NUM_LINES) begin
			line_len[p] = MIN_LINE + rand_below(MAX_LINE - MIN_LINE + 1);
			pix_left[p] = line_len[p];
		end else if (need > 0 && !padded[p]) begin
			// short line so that the port ends on whole bursts
			line_len[p] = need * PIXELS_PER_WORD;
			pix_left[p] = line_len[p];
			padded[p]   = 1'b1;
		end else begin
			port_done[p] = 1'b1;
		end
	endtask

	task automatic drive_pixel(input int p);
		int idx;
		idx   = line_len[p] - pix_left[p];
		de[p] = 1'b1;
		hs[p] = 1'b0;
		vs[p] = 1'b0;
		r[p]  = 8'($random(seed));
		g[p]  = 8'($random(seed));
		b[p]  = 8'($random(seed));
		if (idx < LINE_PIXELS) begin
			build[p][(idx % PIXELS_PER_WORD) * $bits(pixel_t) +: $bits(pixel_t)] =
				pack_565(r[p], g[p], b[p]);
			if (idx % PIXELS_PER_WORD == PIXELS_PER_WORD - 1) begin
				expect_beat(p, build[p], line_no[p], idx / PIXELS_PER_WORD);
				words_made[p]++;
			end
		end
		pix_left[p]--;
		if (pix_left[p] == 0) begin
			line_no[p]++;
			lines_done[p]++;
			start_blank(p);
		end
	endtask

	task automatic drive_blank(input int p);
		de[p] = 1'b0;
		hs[p] = blank_pos[p] < 2;
		// vs pulse kept clear of the falling de
		vs[p] = frame_start[p] && (blank_pos[p] == 2 || blank_pos[p] == 3);
		if (frame_start[p] && blank_pos[p] == 2)
			line_no[p] = 0;
		blank_pos[p]++;
		blank_left[p]--;
		if (blank_left[p] == 0)
			next_line(p);
	endtask

	task automatic step_port(input int p);
		if (port_done[p]) begin
			de[p] = 1'b0;
			hs[p] = 1'b0;
			vs[p] = 1'b0;
		end else if (pix_left[p] > 0) begin
			drive_pixel(p);
		end else begin
			drive_blank(p);
		end
	endtask

	task automatic step_full();
		if (full_left == 0) begin
			if (mem_wr_full) begin
				mem_wr_full = 1'b0;
				full_left   = 5 + rand_below(40);
			end else begin
				mem_wr_full = 1'b1;
				full_left   = 1 + rand_below(16);
			end
		end
		full_left--;
	endtask

	// every beat is matched against the queue of its port
	always @(posedge pclk0) begin
		expected_beat_t exp;
		port_id_t       port;
		if (!vrst) begin
			if (mem_wr_en) begin
				port = port_id_t'(mem_wr_addr / PORT_REGION_BYTES);
				if ((port == 1'b0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
					abort_run($sformatf("beat at address %h but no word expected from port %0d",
						mem_wr_addr, port));
				end else begin
					if (port == 1'b0)
						exp = exp_q0.pop_front();
					else
						exp = exp_q1.pop_front();
					check_word("beat data", exp.data, mem_wr_data);
					check_addr("beat address", exp.addr, mem_wr_addr);
					check_flag("burst command", (beat_total % BURST_WORDS) == 0, mem_cmd_en);
					if (beat_total % BURST_WORDS == 0)
						burst_port = port;
					else
						check_flag("burst port", burst_port, port);
					if (mem_wr_full)
						check_flag("back-pressure full one cycle earlier", 1'b0, prev_full);
					beat_total++;
				end
			end else begin
				check_flag("command without beat", 1'b0, mem_cmd_en);
			end
		end
		prev_full = mem_wr_full;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge pclk0);
		abort_run($sformatf("timeout after %0d cycles with %0d and %0d words still expected",
			TIMEOUT_CYCLES, exp_q0.size(), exp_q1.size()));
	end

	initial begin
		int l;
		int k;
		pclk0       = 1'b0;
		vrst        = 1'b1;
		mem_wr_full = 1'b0;
		seed        = 32'h318d20a5;
		full_left   = 0;
		beat_total  = 0;
		prev_full   = 1'b0;
		burst_port  = 1'b0;
		for (k = 0; k < 2; k++) begin
			hs[k]         = 1'b0;
			vs[k]         = 1'b0;
			de[k]         = 1'b0;
			r[k]          = 8'h00;
			g[k]          = 8'h00;
			b[k]          = 8'h00;
			pix_left[k]   = 0;
			line_len[k]   = 0;
			lines_done[k] = 0;
			line_no[k]    = 0;
			words_made[k] = 0;
			padded[k]     = 1'b0;
			port_done[k]  = 1'b0;
			build[k]      = '0;
			start_blank(k);
			// both cameras open with a frame start
			frame_start[k] = 1'b1;
		end

		repeat (4) @(posedge pclk0);
		@(negedge pclk0);
		vrst = 1'b0;
		check_flag("reset mem_wr_en", 1'b0, mem_wr_en);
		check_flag("reset mem_cmd_en", 1'b0, mem_cmd_en);
		check_flag("reset overflow0", 1'b0, overflow0);
		check_flag("reset overflow1", 1'b0, overflow1);

		while (!(port_done[0] && port_done[1])) begin
			step_port(0);
			step_port(1);
			step_full();
			@(negedge pclk0);
		end

		mem_wr_full = 1'b0;
		while (exp_q0.size() != 0 || exp_q1.size() != 0)
			@(negedge pclk0);
		// a stray beat here would find an empty queue
		repeat (30) @(negedge pclk0);

		// no word may have been dropped while the memory port kept up
		check_flag("overflow0 before fill", 1'b0, overflow0);

		// port 0 alone with the memory port blocked
		mem_wr_full = 1'b1;
		for (l = 0; l < OVF_LINES; l++) begin
			for (k = 0; k < LINE_PIXELS; k++) begin
				de[0] = 1'b1;
				r[0]  = 8'($random(seed));
				g[0]  = 8'($random(seed));
				b[0]  = 8'($random(seed));
				@(negedge pclk0);
			end
			de[0] = 1'b0;
			repeat (MIN_BLANK) @(negedge pclk0);
		end
		check_flag("overflow0 after fill", 1'b1, overflow0);
		check_flag("overflow1 after fill", 1'b0, overflow1);
		check_flag("mem_wr_en while blocked", 1'b0, mem_wr_en);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/burst_writer.sv */
`default_nettype none

module burst_writer
	import mixer_pkg::*;
(
	input  logic        pclk0,
	input  logic        vrst,
	input  logic        beat,
	input  logic        beat_first,
	input  word_entry_t beat_entry,
	input  port_id_t    beat_port,
	output logic        mem_wr_en,
	output logic        mem_cmd_en,
	output mem_word_t   mem_wr_data,
	output mem_addr_t   mem_wr_addr
);
	mem_addr_t port_base;
	mem_addr_t line_off;
	mem_addr_t word_off;
	mem_addr_t beat_addr;

	// each port owns its own region, lines on a fixed stride
	assign port_base = mem_addr_t'(beat_port) * mem_addr_t'(PORT_REGION_BYTES);
	assign line_off  = mem_addr_t'(beat_entry.line) * mem_addr_t'(LINE_STRIDE_BYTES);
	assign word_off  = mem_addr_t'(beat_entry.idx) * mem_addr_t'(WORD_BYTES);
	assign beat_addr = port_base + line_off + word_off;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			mem_wr_en  <= 1'b0;
			mem_cmd_en <= 1'b0;
		end else begin
			mem_wr_en  <= beat;
			// command goes out with the first beat of a burst
			mem_cmd_en <= beat && beat_first;
		end
	end

	always_ff @(posedge pclk0) begin
		if (beat) begin
			mem_wr_data <= beat_entry.data;
			mem_wr_addr <= beat_addr;
		end
	end

endmodule

`default_nettype wire

/* source/mixer.sv */
`default_nettype none

module mixer
	import mixer_pkg::*;
#(
	parameter int LINE_PIXELS = 1024,
	parameter int FIFO_DEPTH  = 64,
	parameter int BURST_WORDS = 4
) (
	input  logic       pclk0,
	input  logic       vrst,
	// camera 0
	input  logic       hs0,
	input  logic       vs0,
	input  logic       de0,
	input  logic [7:0] r0,
	input  logic [7:0] g0,
	input  logic [7:0] b0,
	// camera 1
	input  logic       hs1,
	input  logic       vs1,
	input  logic       de1,
	input  logic [7:0] r1,
	input  logic [7:0] g1,
	input  logic [7:0] b1,
	// memory write port
	input  logic       mem_wr_full,
	output logic       mem_wr_en,
	output logic       mem_cmd_en,
	output mem_word_t  mem_wr_data,
	output mem_addr_t  mem_wr_addr,
	output logic       overflow0,
	output logic       overflow1
);
	logic        push0;
	logic        push1;
	word_entry_t entry0;
	word_entry_t entry1;
	logic        beat;
	logic        beat_first;
	word_entry_t beat_entry;
	port_id_t    beat_port;

	word_stream_if #(.FIFO_DEPTH(FIFO_DEPTH)) s0 ();
	word_stream_if #(.FIFO_DEPTH(FIFO_DEPTH)) s1 ();

	port_packer #(.LINE_PIXELS(LINE_PIXELS)) i_packer0 (
		.pclk0 (pclk0),
		.vrst  (vrst),
		.hs    (hs0),
		.vs    (vs0),
		.de    (de0),
		.r     (r0),
		.g     (g0),
		.b     (b0),
		.push  (push0),
		.entry (entry0)
	);

	port_packer #(.LINE_PIXELS(LINE_PIXELS)) i_packer1 (
		.pclk0 (pclk0),
		.vrst  (vrst),
		.hs    (hs1),
		.vs    (vs1),
		.de    (de1),
		.r     (r1),
		.g     (g1),
		.b     (b1),
		.push  (push1),
		.entry (entry1)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo0 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push0),
		.entry_in (entry0),
		.rd       (s0.fifo_side),
		.overflow (overflow0)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo1 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push1),
		.entry_in (entry1),
		.rd       (s1.fifo_side),
		.overflow (overflow1)
	);

	port_arbiter #(.BURST_WORDS(BURST_WORDS)) i_arbiter (
		.pclk0       (pclk0),
		.vrst        (vrst),
		.mem_wr_full (mem_wr_full),
		.p0          (s0.arb_side),
		.p1          (s1.arb_side),
		.beat        (beat),
		.beat_first  (beat_first),
		.beat_entry  (beat_entry),
		.beat_port   (beat_port)
	);

	burst_writer i_writer (
		.pclk0       (pclk0),
		.vrst        (vrst),
		.beat        (beat),
		.beat_first  (beat_first),
		.beat_entry  (beat_entry),
		.beat_port   (beat_port),
		.mem_wr_en   (mem_wr_en),
		.mem_cmd_en  (mem_cmd_en),
		.mem_wr_data (mem_wr_data),
		.mem_wr_addr (mem_wr_addr)
	);

endmodule

`default_nettype wire

/* source/mixer_pkg.sv */
`default_nettype none

package mixer_pkg;

	// one 5-6-5 pixel, green on top, then red, then blue
	typedef logic [15:0] pixel_t;

	localparam int PIXELS_PER_WORD = 8;

	// first pixel of a group sits in the lowest 16 bits
	typedef logic [PIXELS_PER_WORD*$bits(pixel_t)-1:0] mem_word_t;

	typedef logic [11:0] line_t;
	typedef logic [6:0]  word_idx_t;

	typedef struct packed {
		mem_word_t data;
		line_t     line;
		word_idx_t idx;
	} word_entry_t;

	typedef logic port_id_t;

	// byte address on the memory write port
	typedef logic [29:0] mem_addr_t;

	// address = port * region + line * stride + word * word bytes
	localparam int WORD_BYTES        = 16;
	localparam int LINE_STRIDE_BYTES = 2048;
	localparam int PORT_REGION_BYTES = 1 << 22;

endpackage

`default_nettype wire

/* source/port_arbiter.sv */
`default_nettype none

module port_arbiter
	import mixer_pkg::*;
#(
	parameter int BURST_WORDS = 4
) (
	input  logic           pclk0,
	input  logic           vrst,
	input  logic           mem_wr_full,
	word_stream_if.arb_side p0,
	word_stream_if.arb_side p1,
	output logic           beat,
	output logic           beat_first,
	output word_entry_t    beat_entry,
	output port_id_t       beat_port
);
	localparam int CW = (BURST_WORDS > 1) ? $clog2(BURST_WORDS) : 1;

	typedef enum logic {
		ARB_IDLE,
		ARB_BURST
	} arb_state_t;

	arb_state_t    state;
	port_id_t      sel;
	logic [CW-1:0] beat_cnt;
	logic          p0_ready;
	logic          p1_ready;
	logic          sel_empty;
	logic          take;

	assign p0_ready  = !p0.empty && (p0.level >= BURST_WORDS);
	assign p1_ready  = !p1.empty && (p1.level >= BURST_WORDS);
	assign sel_empty = sel ? p1.empty : p0.empty;
	assign take      = (state == ARB_BURST) && !mem_wr_full && !sel_empty;

	assign p0.pop = take && !sel;
	assign p1.pop = take && sel;

	// the pop itself is the beat, burst_writer captures it at the next edge
	assign beat       = take;
	assign beat_first = take && (beat_cnt == '0);
	assign beat_entry = sel ? p1.entry : p0.entry;
	assign beat_port  = sel;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			state    <= ARB_IDLE;
			sel      <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
			ARB_IDLE: begin
				beat_cnt <= '0;
				if (!mem_wr_full) begin
					// fuller port wins, port 0 on a tie
					if (p1_ready && (p1.level > p0.level)) begin
						sel   <= 1'b1;
						state <= ARB_BURST;
					end else if (p0_ready) begin
						sel   <= 1'b0;
						state <= ARB_BURST;
					end else if (p1_ready) begin
						sel   <= 1'b1;
						state <= ARB_BURST;
					end
				end
			end
			ARB_BURST: begin
				if (take) begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == CW'(BURST_WORDS - 1))
						state <= ARB_IDLE;
				end
			end
			default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/port_packer.sv */
`default_nettype none

module port_packer
	import mixer_pkg::*;
#(
	parameter int LINE_PIXELS = 1024
) (
	input  logic        pclk0,
	input  logic        vrst,
	input  logic        hs,
	input  logic        vs,
	input  logic        de,
	input  logic [7:0]  r,
	input  logic [7:0]  g,
	input  logic [7:0]  b,
	output logic        push,
	output word_entry_t entry
);
	localparam int IW = $clog2(LINE_PIXELS + 1);

	logic          vs_d;
	logic          de_d;
	logic          vs_rise;
	logic          de_rise;
	logic          de_fall;
	logic [IW-1:0] pix_cnt;
	logic [IW-1:0] pix_idx;
	logic          pix_take;
	logic          word_done;
	line_t         line_cnt;
	line_t         line_now;
	pixel_t        pix;
	mem_word_t     acc;
	mem_word_t     acc_next;

	assign vs_rise = vs && !vs_d;
	assign de_rise = de && !de_d;
	assign de_fall = !de && de_d;

	// index restarts on the first pixel of a line
	assign pix_idx   = de_rise ? '0 : pix_cnt;
	assign pix_take  = de && (pix_idx < IW'(LINE_PIXELS));
	assign word_done = pix_take && ((pix_idx % PIXELS_PER_WORD) == PIXELS_PER_WORD - 1);
	assign line_now  = vs_rise ? '0 : line_cnt;

	assign pix      = {g[7:2], r[7:3], b[7:3]};
	assign acc_next = {pix, acc[$bits(mem_word_t)-1:$bits(pixel_t)]};

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			vs_d     <= 1'b0;
			de_d     <= 1'b0;
			line_cnt <= '0;
			pix_cnt  <= '0;
			push     <= 1'b0;
		end else begin
			vs_d <= vs;
			de_d <= de;
			if (vs_rise)
				line_cnt <= '0;
			else if (de_fall)
				line_cnt <= line_cnt + 1'b1;
			if (pix_take)
				pix_cnt <= pix_idx + 1'b1;
			push <= word_done;
		end
	end

	// newest pixel enters at the top, so the first one ends up lowest
	always_ff @(posedge pclk0) begin
		if (pix_take)
			acc <= acc_next;
		else if (hs)
			acc <= '0;
		if (word_done) begin
			entry.data <= acc_next;
			entry.line <= line_now;
			entry.idx  <= word_idx_t'(pix_idx / PIXELS_PER_WORD);
		end
	end

endmodule

`default_nettype wire

/* source/word_fifo.sv */
`default_nettype none

module word_fifo
	import mixer_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
) (
	input  logic             pclk0,
	input  logic             vrst,
	input  logic             push,
	input  word_entry_t      entry_in,
	word_stream_if.fifo_side rd,
	output logic             overflow
);
	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LW = $clog2(FIFO_DEPTH + 1);

	word_entry_t   mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [LW-1:0] count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full     = count == LW'(FIFO_DEPTH);
	assign do_pop   = rd.pop && !rd.empty;
	// a pop in the same cycle frees the slot for the push
	assign do_push  = push && (!full || do_pop);
	assign rd.entry = mem[rd_ptr];
	assign rd.level = count;
	assign rd.empty = count == '0;

	always_ff @(posedge pclk0) begin
		if (do_push)
			mem[wr_ptr] <= entry_in;
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			// dropped word, held until reset
			if (push && !do_push)
				overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/word_stream_if.sv */
`default_nettype none

interface word_stream_if
	import mixer_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
);
	localparam int LW = $clog2(FIFO_DEPTH + 1);

	// head entry, valid while empty is low
	word_entry_t   entry;
	logic          pop;
	// number of entries waiting
	logic [LW-1:0] level;
	logic          empty;

	modport fifo_side (
		output entry,
		output level,
		output empty,
		input  pop
	);

	modport arb_side (
		input  entry,
		input  level,
		input  empty,
		output pop
	);

endinterface

`default_nettype wire
